// ==== src/lsb_link_pkg.sv ====
package lsb_link_pkg;

  // ##########################################################################
  // target memory geometry
  // ##########################################################################

  localparam int MEM_WORDS  = 16;
  localparam int ADDR_WIDTH = $clog2(MEM_WORDS);
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;

  // ##########################################################################
  // link payloads
  // ##########################################################################

  // folded aw/ar/w request
  typedef struct packed {
    logic                  write;  // 1 = write, 0 = read
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;   // word address
    logic [DATA_WIDTH-1:0] wdata;  // ignored for reads
  } lsb_req_t;

  // folded b/r response
  typedef struct packed {
    logic                  write;  // echoed from the request
    logic [ID_WIDTH-1:0]   id;     // echoed from the request
    logic [DATA_WIDTH-1:0] rdata;  // zero for writes
  } lsb_resp_t;

endpackage

// ==== src/lsb_fifo_pkg.sv ====
package lsb_fifo_pkg;

  localparam int BUFFER_DEPTH = 4;
  localparam int IDX_WIDTH    = $clog2(BUFFER_DEPTH);
  localparam int PTR_WIDTH    = IDX_WIDTH + 1;  // index plus wrap bit

  typedef logic [PTR_WIDTH-1:0] lsb_ptr_t;

  // full when the read pointer equals the write token with top two bits flipped
  localparam lsb_ptr_t FULL_MASK = {2'b11, {(PTR_WIDTH-2){1'b0}}};

  function automatic lsb_ptr_t bin2gray(lsb_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

// ==== src/lsb_token_tx.sv ====
`timescale 1ns/1ps

module lsb_token_tx
  import lsb_fifo_pkg::*;
#(
  parameter type payload_t = logic
)
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic                         valid_i,
  input  payload_t                     data_i,
  output logic                         ready_o,
  output payload_t [BUFFER_DEPTH-1:0]  slots_o,
  output lsb_ptr_t                     wtoken_o,
  input  lsb_ptr_t                     rptr_i
);

  lsb_ptr_t wbin_q;      // binary write count
  lsb_ptr_t wbin_nxt;
  lsb_ptr_t rptr_s1_q;   // first sync stage
  lsb_ptr_t rptr_s2_q;   // synchronized read pointer
  logic     full;
  logic     push;

  // ##########################################################################
  // read pointer synchronizer
  // ##########################################################################

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      rptr_s1_q <= '0;
      rptr_s2_q <= '0;
    end
    else
    begin
      rptr_s1_q <= rptr_i;
      rptr_s2_q <= rptr_s1_q;
    end
  end

  assign full     = (rptr_s2_q == (wtoken_o ^ FULL_MASK));
  assign ready_o  = ~full;
  assign push     = valid_i & ~full;
  assign wbin_nxt = wbin_q + 1'b1;

  // ##########################################################################
  // write counter and token
  // ##########################################################################

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      wbin_q   <= '0;
      wtoken_o <= '0;
    end
    else if (push)
    begin
      wbin_q   <= wbin_nxt;
      wtoken_o <= bin2gray(wbin_nxt);  // token moves on the same edge as the slot
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      slots_o[wbin_q[IDX_WIDTH-1:0]] <= data_i;
    end
  end

endmodule

// ==== src/lsb_token_rx.sv ====
`timescale 1ns/1ps

module lsb_token_rx
  import lsb_fifo_pkg::*;
#(
  parameter type payload_t = logic
)
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  payload_t [BUFFER_DEPTH-1:0]  slots_i,
  input  lsb_ptr_t                     wtoken_i,
  output logic                         valid_o,
  output payload_t                     data_o,
  input  logic                         ready_i,
  output lsb_ptr_t                     rptr_o
);

  lsb_ptr_t rbin_q;       // binary read count
  lsb_ptr_t rbin_nxt;
  lsb_ptr_t wtok_s1_q;    // first sync stage
  lsb_ptr_t wtok_s2_q;    // synchronized write token
  logic     pop;

  // ##########################################################################
  // write token synchronizer
  // ##########################################################################

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      wtok_s1_q <= '0;
      wtok_s2_q <= '0;
    end
    else
    begin
      wtok_s1_q <= wtoken_i;
      wtok_s2_q <= wtok_s1_q;
    end
  end

  assign valid_o  = (wtok_s2_q != rptr_o);
  assign data_o   = slots_i[rbin_q[IDX_WIDTH-1:0]];  // head slot
  assign pop      = valid_o & ready_i;
  assign rbin_nxt = rbin_q + 1'b1;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      rbin_q <= '0;
      rptr_o <= '0;
    end
    else if (pop)
    begin
      rbin_q <= rbin_nxt;
      rptr_o <= bin2gray(rbin_nxt);
    end
  end

endmodule

// ==== src/lsb_iso_wrap.sv ====
`timescale 1ns/1ps

module lsb_iso_wrap
  import lsb_link_pkg::*;
  import lsb_fifo_pkg::*;
(
  input  logic                          power_down_i,

  // request buffer, always-on side writes
  input  lsb_req_t  [BUFFER_DEPTH-1:0]  req_slots_i,
  input  lsb_ptr_t                      req_wtoken_i,
  output lsb_req_t  [BUFFER_DEPTH-1:0]  req_slots_o,
  output lsb_ptr_t                      req_wtoken_o,
  input  lsb_ptr_t                      req_rptr_i,
  output lsb_ptr_t                      req_rptr_o,

  // response buffer, switchable side writes
  input  lsb_resp_t [BUFFER_DEPTH-1:0]  rsp_slots_i,
  input  lsb_ptr_t                      rsp_wtoken_i,
  output lsb_resp_t [BUFFER_DEPTH-1:0]  rsp_slots_o,
  output lsb_ptr_t                      rsp_wtoken_o,
  input  lsb_ptr_t                      rsp_rptr_i,
  output lsb_ptr_t                      rsp_rptr_o
);

  genvar g;

  // ##########################################################################
  // into the switchable domain
  // ##########################################################################

  assign req_slots_o  = req_slots_i;
  assign req_wtoken_o = req_wtoken_i;
  assign rsp_rptr_o   = rsp_rptr_i;

  // ##########################################################################
  // out of the switchable domain, clamped low while powered down
  // ##########################################################################

  assign req_rptr_o   = power_down_i ? '0 : req_rptr_i;
  assign rsp_wtoken_o = power_down_i ? '0 : rsp_wtoken_i;

  for (g = 0; g < BUFFER_DEPTH; g++)
  begin : g_rsp_slot_clamp
    assign rsp_slots_o[g] = power_down_i ? '0 : rsp_slots_i[g];  // one clamp per slot
  end

endmodule

// ==== src/lsb_mem_target.sv ====
`timescale 1ns/1ps

module lsb_mem_target
  import lsb_link_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       power_down_i,

  input  logic       req_valid_i,
  input  lsb_req_t   req_i,
  output logic       req_ready_o,

  output logic       rsp_valid_o,
  output lsb_resp_t  rsp_o,
  input  logic       rsp_ready_i
);

  logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
  lsb_resp_t             rsp_q;   // one-entry response register
  logic                  busy_q;  // response register holds an answer
  logic                  take;

  // accept when empty or when the held response leaves this cycle
  assign req_ready_o = ~busy_q | rsp_ready_i;
  assign take        = req_valid_i & req_ready_o;
  assign rsp_valid_o = busy_q;
  assign rsp_o       = rsp_q;

  // ##########################################################################
  // control
  // ##########################################################################

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || power_down_i)
    begin
      busy_q <= 1'b0;
    end
    else if (take)
    begin
      busy_q <= 1'b1;
    end
    else if (rsp_ready_i)
    begin
      busy_q <= 1'b0;  // drained, nothing new
    end
  end

  // ##########################################################################
  // storage and response
  // ##########################################################################

  // the domain loses its contents when switched off
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || power_down_i)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
      begin
        mem_q[i] <= '0;
      end
      rsp_q <= '0;
    end
    else if (take)
    begin
      if (req_i.write)
      begin
        mem_q[req_i.addr] <= req_i.wdata;
      end
      rsp_q.write <= req_i.write;
      rsp_q.id    <= req_i.id;
      rsp_q.rdata <= req_i.write ? '0 : mem_q[req_i.addr];
    end
  end

endmodule

// ==== src/lsb_bridge_top.sv ====
`timescale 1ns/1ps

module lsb_bridge_top
  import lsb_link_pkg::*;
  import lsb_fifo_pkg::*;
(
  input  logic       clk_mst_i,
  input  logic       clk_slv_i,
  input  logic       rst_n_i,
  input  logic       power_down_i,

  input  logic       req_valid_i,
  input  lsb_req_t   req_i,
  output logic       req_ready_o,

  output logic       resp_valid_o,
  output lsb_resp_t  resp_o,
  input  logic       resp_ready_i
);

  // request path, always-on to switchable
  lsb_req_t  [BUFFER_DEPTH-1:0] req_slots_mst;
  lsb_req_t  [BUFFER_DEPTH-1:0] req_slots_slv;
  lsb_ptr_t                     req_wtoken_mst;
  lsb_ptr_t                     req_wtoken_slv;
  lsb_ptr_t                     req_rptr_slv;
  lsb_ptr_t                     req_rptr_mst;

  // response path, switchable to always-on
  lsb_resp_t [BUFFER_DEPTH-1:0] rsp_slots_slv;
  lsb_resp_t [BUFFER_DEPTH-1:0] rsp_slots_mst;
  lsb_ptr_t                     rsp_wtoken_slv;
  lsb_ptr_t                     rsp_wtoken_mst;
  lsb_ptr_t                     rsp_rptr_mst;
  lsb_ptr_t                     rsp_rptr_slv;

  // target side handshakes
  logic       tgt_req_valid;
  logic       tgt_req_ready;
  lsb_req_t   tgt_req;
  logic       tgt_rsp_valid;
  logic       tgt_rsp_ready;
  lsb_resp_t  tgt_rsp;

  // ##########################################################################
  // always-on domain
  // ##########################################################################

  lsb_token_tx #(.payload_t(lsb_req_t)) u_req_tx (
    .clk_i    (clk_mst_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (power_down_i),
    .valid_i  (req_valid_i),
    .data_i   (req_i),
    .ready_o  (req_ready_o),
    .slots_o  (req_slots_mst),
    .wtoken_o (req_wtoken_mst),
    .rptr_i   (req_rptr_mst)
  );

  lsb_token_rx #(.payload_t(lsb_resp_t)) u_rsp_rx (
    .clk_i    (clk_mst_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (power_down_i),
    .slots_i  (rsp_slots_mst),
    .wtoken_i (rsp_wtoken_mst),
    .valid_o  (resp_valid_o),
    .data_o   (resp_o),
    .ready_i  (resp_ready_i),
    .rptr_o   (rsp_rptr_mst)
  );

  lsb_iso_wrap u_iso (
    .power_down_i (power_down_i),
    .req_slots_i  (req_slots_mst),
    .req_wtoken_i (req_wtoken_mst),
    .req_slots_o  (req_slots_slv),
    .req_wtoken_o (req_wtoken_slv),
    .req_rptr_i   (req_rptr_slv),
    .req_rptr_o   (req_rptr_mst),
    .rsp_slots_i  (rsp_slots_slv),
    .rsp_wtoken_i (rsp_wtoken_slv),
    .rsp_slots_o  (rsp_slots_mst),
    .rsp_wtoken_o (rsp_wtoken_mst),
    .rsp_rptr_i   (rsp_rptr_mst),
    .rsp_rptr_o   (rsp_rptr_slv)
  );

  // ##########################################################################
  // switchable domain
  // ##########################################################################

  lsb_token_rx #(.payload_t(lsb_req_t)) u_req_rx (
    .clk_i    (clk_slv_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (power_down_i),
    .slots_i  (req_slots_slv),
    .wtoken_i (req_wtoken_slv),
    .valid_o  (tgt_req_valid),
    .data_o   (tgt_req),
    .ready_i  (tgt_req_ready),
    .rptr_o   (req_rptr_slv)
  );

  lsb_mem_target u_tgt (
    .clk_i        (clk_slv_i),
    .rst_n_i      (rst_n_i),
    .power_down_i (power_down_i),
    .req_valid_i  (tgt_req_valid),
    .req_i        (tgt_req),
    .req_ready_o  (tgt_req_ready),
    .rsp_valid_o  (tgt_rsp_valid),
    .rsp_o        (tgt_rsp),
    .rsp_ready_i  (tgt_rsp_ready)
  );

  lsb_token_tx #(.payload_t(lsb_resp_t)) u_rsp_tx (
    .clk_i    (clk_slv_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (power_down_i),
    .valid_i  (tgt_rsp_valid),
    .data_i   (tgt_rsp),
    .ready_o  (tgt_rsp_ready),  // target stalls while this buffer is full
    .slots_o  (rsp_slots_slv),
    .wtoken_o (rsp_wtoken_slv),
    .rptr_i   (rsp_rptr_slv)
  );

endmodule

// ==== bench/lsb_bridge_tb.sv ====
`timescale 1ns/1ps

module lsb_bridge_tb
  import lsb_link_pkg::*;
  import lsb_fifo_pkg::*;
();

  localparam int TABLE_LEN  = 13;
  localparam int WAIT_LIMIT = 200;  // cycles allowed for any single wait
  localparam int STALL_RUN  = 30;   // ready low this long counts as stalled

  typedef struct packed {
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [ID_WIDTH-1:0]   id;
    logic                  hold;  // leave resp_ready_i low so the response stays pending
  } stim_t;

  logic       clk_mst_i;
  logic       clk_slv_i;
  logic       rst_n_i;
  logic       power_down_i;
  logic       req_valid_i;
  lsb_req_t   req_i;
  logic       req_ready_o;
  logic       resp_valid_o;
  lsb_resp_t  resp_o;
  logic       resp_ready_i;

  stim_t                 stim_table [TABLE_LEN];
  logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
  logic                  written [MEM_WORDS];
  lsb_resp_t             exp_q [$];
  logic [15:0]           lfsr_q;

  lsb_bridge_top u_dut (
    .clk_mst_i    (clk_mst_i),
    .clk_slv_i    (clk_slv_i),
    .rst_n_i      (rst_n_i),
    .power_down_i (power_down_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i)
  );

  always #10 clk_mst_i = ~clk_mst_i;

  always
  begin
    #5;
    clk_slv_i = ~clk_slv_i;  // same period with edges 5 ns apart
    #5;
  end

  // ##########################################################################
  // failure reporting and checks
  // ##########################################################################

  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    stop_with_failure();
  endtask

  task automatic check_resp(input lsb_resp_t got, input lsb_resp_t exp);
    if (got !== exp)
    begin
      $display("Error: resp_o got 0x%h expected 0x%h", got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // reference memory updated in request order
  task automatic model_request(input lsb_req_t req);
    lsb_resp_t exp;
    exp.write = req.write;
    exp.id    = req.id;
    exp.rdata = req.write ? '0 : ref_mem[req.addr];
    if (req.write)
    begin
      ref_mem[req.addr] = req.wdata;
      written[req.addr] = 1'b1;
    end
    exp_q.push_back(exp);
  endtask

  // ##########################################################################
  // request and response handshakes
  // ##########################################################################

  task automatic issue_request(input lsb_req_t req);
    int waited;
    waited      = 0;
    req_valid_i = 1'b1;
    req_i       = req;
    while (!req_ready_o)
    begin
      @(negedge clk_mst_i);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("request was never accepted, req_ready_o stayed low");
    end
    model_request(req);
    @(negedge clk_mst_i);  // transfer happens on the rising edge in between
  endtask

  task automatic drain_responses();
    int          waited;
    logic [31:0] bits;
    waited = 0;
    while (exp_q.size() > 0)
    begin
      @(negedge clk_mst_i);
      draw_bits(1, bits);
      resp_ready_i = bits[0];
      if (resp_valid_o && resp_ready_i)
      begin
        check_resp(resp_o, exp_q.pop_front());
        waited = 0;
      end
      else
      begin
        waited++;
        if (waited > WAIT_LIMIT)
          abort_run("expected response did not arrive before the timeout");
      end
    end
    @(negedge clk_mst_i);
    resp_ready_i = 1'b0;
  endtask

  task automatic settle_idle();
    int waited;
    waited = 0;
    while (!req_ready_o)
    begin
      @(negedge clk_mst_i);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("req_ready_o did not return high after draining");
    end
    repeat (6)
    begin
      @(negedge clk_mst_i);
      check_flag("resp_valid_o", resp_valid_o, 1'b0);  // no stray response
    end
  endtask

  // ##########################################################################
  // test phases
  // ##########################################################################

  task automatic load_table();
    stim_table[0]  = '{1'b1, 4'h1, 32'hDEAD_BEEF, 4'd1, 1'b0};
    stim_table[1]  = '{1'b1, 4'h5, 32'h1234_5678, 4'd2, 1'b0};
    stim_table[2]  = '{1'b1, 4'hA, 32'hCAFE_F00D, 4'd3, 1'b0};
    stim_table[3]  = '{1'b1, 4'hF, 32'h0BAD_F00D, 4'd4, 1'b0};
    stim_table[4]  = '{1'b0, 4'h1, 32'h0000_0000, 4'd5, 1'b0};
    stim_table[5]  = '{1'b0, 4'h5, 32'h0000_0000, 4'd6, 1'b0};
    stim_table[6]  = '{1'b0, 4'hA, 32'h0000_0000, 4'd7, 1'b0};
    stim_table[7]  = '{1'b0, 4'hF, 32'h0000_0000, 4'd8, 1'b0};
    stim_table[8]  = '{1'b1, 4'h3, 32'hA5A5_5A5A, 4'd9, 1'b1};   // back to back group
    stim_table[9]  = '{1'b0, 4'h3, 32'h0000_0000, 4'd10, 1'b1};
    stim_table[10] = '{1'b1, 4'h1, 32'h0000_1111, 4'd11, 1'b1};
    stim_table[11] = '{1'b0, 4'hF, 32'h0000_0000, 4'd12, 1'b0};
    stim_table[12] = '{1'b0, 4'h1, 32'h0000_0000, 4'd13, 1'b0};
  endtask

  task automatic run_table();
    lsb_req_t req;
    for (int t = 0; t < TABLE_LEN; t++)
    begin
      req.write = stim_table[t].write;
      req.id    = stim_table[t].id;
      req.addr  = stim_table[t].addr;
      req.wdata = stim_table[t].data;
      issue_request(req);
      if (!stim_table[t].hold)
      begin
        req_valid_i = 1'b0;
        drain_responses();
      end
    end
    req_valid_i = 1'b0;
  endtask

  // fill both buffers with resp_ready_i low until req_ready_o stays down
  task automatic run_stall();
    lsb_req_t    req;
    logic [31:0] bits;
    logic        need_new;
    int          accepted;
    int          low_run;
    int          cycles;
    need_new = 1'b1;
    accepted = 0;
    low_run  = 0;
    cycles   = 0;
    while (low_run < STALL_RUN)
    begin
      if (need_new)
      begin
        draw_bits(1, bits);
        req.write = bits[0];
        draw_bits(ADDR_WIDTH, bits);
        req.addr = bits[ADDR_WIDTH-1:0];
        draw_bits(DATA_WIDTH, bits);
        req.wdata   = req.write ? bits : '0;
        req.id      = ID_WIDTH'(accepted);
        req_i       = req;
        req_valid_i = 1'b1;
        need_new    = 1'b0;
      end
      if (req_ready_o)
      begin
        model_request(req);
        accepted++;
        need_new = 1'b1;
        low_run  = 0;
      end
      else
      begin
        low_run++;
      end
      cycles++;
      if (cycles > WAIT_LIMIT)
        abort_run("req_ready_o never fell while responses were held back");
      @(negedge clk_mst_i);
    end
    req_valid_i = 1'b0;  // the refused request is withdrawn
    check_flag("req_ready_o", req_ready_o, 1'b0);
    if (accepted < 2 * BUFFER_DEPTH)
      abort_run("fewer requests were accepted than the two buffers can hold");
    drain_responses();
  endtask

  task automatic power_cycle_and_read();
    lsb_req_t req;
    power_down_i = 1'b1;
    repeat (8)
    begin
      @(negedge clk_mst_i);
      check_flag("resp_valid_o", resp_valid_o, 1'b0);
    end
    power_down_i = 1'b0;
    for (int a = 0; a < MEM_WORDS; a++)
      ref_mem[a] = '0;  // switchable domain lost its contents
    @(negedge clk_mst_i);
    for (int a = 0; a < MEM_WORDS; a++)
    begin
      if (written[a])
      begin
        req.write = 1'b0;
        req.id    = ID_WIDTH'(a);
        req.addr  = ADDR_WIDTH'(a);
        req.wdata = '0;
        issue_request(req);
        req_valid_i = 1'b0;
        drain_responses();
      end
    end
  endtask

  initial
  begin
    clk_mst_i    = 1'b0;
    clk_slv_i    = 1'b0;
    rst_n_i      = 1'b0;
    power_down_i = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b0;
    lfsr_q       = 16'd68;
    for (int a = 0; a < MEM_WORDS; a++)
    begin
      ref_mem[a] = '0;
      written[a] = 1'b0;
    end
    load_table();
    repeat (8) @(negedge clk_mst_i);
    rst_n_i = 1'b1;
    @(negedge clk_mst_i);
    check_flag("resp_valid_o", resp_valid_o, 1'b0);
    check_flag("req_ready_o", req_ready_o, 1'b1);

    run_table();
    run_stall();
    settle_idle();
    power_cycle_and_read();
    settle_idle();

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== lsb_bridge.f ====
src/lsb_link_pkg.sv
src/lsb_fifo_pkg.sv
src/lsb_token_tx.sv
src/lsb_token_rx.sv
src/lsb_iso_wrap.sv
src/lsb_mem_target.sv
src/lsb_bridge_top.sv
bench/lsb_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lsb_bridge_tb \
  -f lsb_bridge.f -o lsb_bridge_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

sim_out=$(./obj_dir/lsb_bridge_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Verification passed$"; then
  exit 0
fi
echo "pass message not found"
exit 1
